/* reg_block.f */
+incdir+test
source/reg_block_pkg.sv
source/reg_bus_adapter.sv
source/reg_register.sv
source/reg_event_counter.sv
source/reg_block.sv
test/reg_block_tb.sv

/* source/reg_block.sv */
`timescale 1ns/1ps

module reg_block #(
  parameter int                   bus_width     = 32,
  parameter int                   address_width = 8,
  parameter int                   registers     = 3,
  parameter logic [reg_block_pkg::reg_status_width-1:0]
                                  error_status  = reg_block_pkg::reg_status_decode_error,
  parameter logic [bus_width-1:0] error_data    = '0,
  parameter int                   counter_width = 16
)(
  input  logic                                       i_clk,
  input  logic                                       i_rst_n,
  input  logic                                       valid,
  input  logic [address_width-1:0]                   address,
  input  logic                                       write,
  input  logic [bus_width-1:0]                       write_data,
  input  logic [bus_width/8-1:0]                     strobe,
  output logic                                       ready,
  output logic [reg_block_pkg::reg_status_width-1:0] status,
  output logic [bus_width-1:0]                       read_data,
  input  logic [bus_width-1:0]                       hw_status,
  input  logic                                       event_pulse,
  output logic [bus_width-1:0]                       ctrl_value
);
  import reg_block_pkg::*;

  // Slot order behind the adapter.
  localparam int ctrl_slot    = 0;
  localparam int status_slot  = 1;
  localparam int counter_slot = 2;

  logic [registers-1:0]                       reg_valid;
  logic [registers-1:0]                       reg_active;
  logic [registers-1:0]                       reg_ready;
  logic [registers-1:0][reg_status_width-1:0] reg_status;
  logic [registers-1:0][bus_width-1:0]        reg_read_data;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus side.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  reg_bus_adapter #(
    .bus_width     (bus_width),
    .address_width (address_width),
    .registers     (registers),
    .error_status  (error_status),
    .error_data    (error_data)
  ) u_adapter (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .valid         (valid),
    .address       (address),
    .write         (write),
    .write_data    (write_data),
    .strobe        (strobe),
    .ready         (ready),
    .status        (status),
    .read_data     (read_data),
    .reg_valid     (reg_valid),
    .reg_active    (reg_active),
    .reg_ready     (reg_ready),
    .reg_status    (reg_status),
    .reg_read_data (reg_read_data)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Registers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control, fully writable, no hardware value behind it.
  reg_register #(
    .bus_width     (bus_width),
    .address_width (address_width),
    .base_address  (address_width'('h00)),
    .writable_mask ({bus_width{1'b1}})
  ) u_ctrl_register (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .reg_valid     (reg_valid[ctrl_slot]),
    .address       (address),
    .write         (write),
    .write_data    (write_data),
    .strobe        (strobe),
    .hw_value      ({bus_width{1'b0}}),
    .reg_active    (reg_active[ctrl_slot]),
    .reg_ready     (reg_ready[ctrl_slot]),
    .reg_status    (reg_status[ctrl_slot]),
    .reg_read_data (reg_read_data[ctrl_slot]),
    .value         (ctrl_value)
  );

  // Status, read-only view of the hardware input.
  reg_register #(
    .bus_width     (bus_width),
    .address_width (address_width),
    .base_address  (address_width'('h04)),
    .writable_mask ({bus_width{1'b0}})
  ) u_status_register (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .reg_valid     (reg_valid[status_slot]),
    .address       (address),
    .write         (write),
    .write_data    (write_data),
    .strobe        (strobe),
    .hw_value      (hw_status),
    .reg_active    (reg_active[status_slot]),
    .reg_ready     (reg_ready[status_slot]),
    .reg_status    (reg_status[status_slot]),
    .reg_read_data (reg_read_data[status_slot]),
    .value         ()
  );

  reg_event_counter #(
    .bus_width     (bus_width),
    .address_width (address_width),
    .base_address  (address_width'('h08)),
    .counter_width (counter_width)
  ) u_event_counter (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .reg_valid     (reg_valid[counter_slot]),
    .address       (address),
    .write         (write),
    .write_data    (write_data),
    .strobe        (strobe),
    .event_pulse   (event_pulse),
    .reg_active    (reg_active[counter_slot]),
    .reg_ready     (reg_ready[counter_slot]),
    .reg_status    (reg_status[counter_slot]),
    .reg_read_data (reg_read_data[counter_slot])
  );

endmodule

/* source/reg_block_pkg.sv */
package reg_block_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response status codes.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int reg_status_width = 2;

  localparam logic [reg_status_width-1:0] reg_status_okay         = 2'd0;
  localparam logic [reg_status_width-1:0] reg_status_exokay       = 2'd1;
  localparam logic [reg_status_width-1:0] reg_status_slave_error  = 2'd2;
  localparam logic [reg_status_width-1:0] reg_status_decode_error = 2'd3;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // One-hot response select.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Callers pad narrower words and unused slots with zeros.
  localparam int reg_select_slots = 8;
  localparam int reg_select_width = 64;

  function automatic logic [reg_select_width-1:0] reg_select(
    input logic [reg_select_slots-1:0]                       select,
    input logic [reg_select_slots-1:0][reg_select_width-1:0] words
  );
    logic [reg_select_width-1:0] result;
    result = '0;
    for (int i = 0; i < reg_select_slots; i++) begin
      result |= words[i] & {reg_select_width{select[i]}};
    end
    return result;
  endfunction

endpackage

/* source/reg_bus_adapter.sv */
`timescale 1ns/1ps

module reg_bus_adapter #(
  parameter int                                   bus_width     = 32,
  parameter int                                   address_width = 8,
  parameter int                                   registers     = 1,
  parameter logic [reg_block_pkg::reg_status_width-1:0]
                                                  error_status  =
                                                    reg_block_pkg::reg_status_decode_error,
  parameter logic [bus_width-1:0]                 error_data    = '0
)(
  input  logic                                   i_clk,
  input  logic                                   i_rst_n,
  input  logic                                   valid,
  input  logic [address_width-1:0]               address,
  input  logic                                   write,
  input  logic [bus_width-1:0]                   write_data,
  input  logic [bus_width/8-1:0]                 strobe,
  output logic                                   ready,
  output logic [reg_block_pkg::reg_status_width-1:0] status,
  output logic [bus_width-1:0]                   read_data,
  output logic [registers-1:0]                   reg_valid,
  input  logic [registers-1:0]                   reg_active,
  input  logic [registers-1:0]                   reg_ready,
  input  logic [registers-1:0][reg_block_pkg::reg_status_width-1:0] reg_status,
  input  logic [registers-1:0][bus_width-1:0]    reg_read_data
);
  import reg_block_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Busy state.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic busy;
  logic request;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy <= 1'b0;
    end else if (ready) begin
      busy <= 1'b0;
    end else if (valid) begin
      busy <= 1'b1;
    end
  end

  // Request is broadcast once and then held off until a response.
  assign request   = valid && !busy;
  assign reg_valid = {registers{request}};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response merge.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic                                              error_ready;
  logic [reg_select_slots-1:0]                       select;
  logic [reg_select_slots-1:0][reg_select_width-1:0] status_words;
  logic [reg_select_slots-1:0][reg_select_width-1:0] data_words;
  logic [reg_select_width-1:0]                       merged_status;
  logic [reg_select_width-1:0]                       merged_data;

  // Nobody claims the address, so the extra slot answers.
  assign error_ready = valid && !(|reg_active);

  always_comb begin
    select       = '0;
    status_words = '0;
    data_words   = '0;
    for (int i = 0; i < registers; i++) begin
      select[i]       = reg_ready[i];
      status_words[i] = reg_select_width'(reg_status[i]);
      data_words[i]   = reg_select_width'(reg_read_data[i]);
    end
    select[registers]       = error_ready;
    status_words[registers] = reg_select_width'(error_status);
    data_words[registers]   = reg_select_width'(error_data);
  end

  assign merged_status = reg_select(select, status_words);
  assign merged_data   = reg_select(select, data_words);

  assign ready     = |select;
  assign status    = merged_status[reg_status_width-1:0];
  assign read_data = merged_data[bus_width-1:0];

endmodule

/* source/reg_event_counter.sv */
`timescale 1ns/1ps

module reg_event_counter #(
  parameter int                       bus_width     = 32,
  parameter int                       address_width = 8,
  parameter logic [address_width-1:0] base_address  = '0,
  parameter int                       counter_width = 16
)(
  input  logic                                       i_clk,
  input  logic                                       i_rst_n,
  input  logic                                       reg_valid,
  input  logic [address_width-1:0]                   address,
  input  logic                                       write,
  input  logic [bus_width-1:0]                       write_data,
  input  logic [bus_width/8-1:0]                     strobe,
  input  logic                                       event_pulse,
  output logic                                       reg_active,
  output logic                                       reg_ready,
  output logic [reg_block_pkg::reg_status_width-1:0] reg_status,
  output logic [bus_width-1:0]                       reg_read_data
);
  import reg_block_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address decode.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic clear;

  assign reg_active = (address[address_width-1:2] == base_address[address_width-1:2]);
  assign reg_ready  = reg_valid && reg_active;

  // Any completed write clears, data and strobe are don't care.
  assign clear = reg_ready && write;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Saturating counter.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic [counter_width-1:0] count;
  logic                     saturated;

  assign saturated = &count;

  // Clear wins over an event in the same cycle.
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (event_pulse && !saturated) begin
      count <= count + counter_width'(1);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    reg_read_data = '0;
    if (reg_ready) begin
      reg_read_data = bus_width'(count);
    end
  end

  assign reg_status = reg_status_okay;

endmodule

/* source/reg_register.sv */
`timescale 1ns/1ps

module reg_register #(
  parameter int                       bus_width     = 32,
  parameter int                       address_width = 8,
  parameter logic [address_width-1:0] base_address  = '0,
  parameter logic [bus_width-1:0]     writable_mask = '1
)(
  input  logic                                       i_clk,
  input  logic                                       i_rst_n,
  input  logic                                       reg_valid,
  input  logic [address_width-1:0]                   address,
  input  logic                                       write,
  input  logic [bus_width-1:0]                       write_data,
  input  logic [bus_width/8-1:0]                     strobe,
  input  logic [bus_width-1:0]                       hw_value,
  output logic                                       reg_active,
  output logic                                       reg_ready,
  output logic [reg_block_pkg::reg_status_width-1:0] reg_status,
  output logic [bus_width-1:0]                       reg_read_data,
  output logic [bus_width-1:0]                       value
);
  import reg_block_pkg::*;

  localparam int strobe_width = bus_width / 8;

  // No writable bit at all means the register is read-only.
  localparam bit read_only = (writable_mask == '0);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address decode.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic write_hit;

  // Word aligned, the byte offset bits are ignored.
  assign reg_active = (address[address_width-1:2] == base_address[address_width-1:2]);
  assign reg_ready  = reg_valid && reg_active;
  assign write_hit  = reg_ready && write;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic [bus_width-1:0] byte_mask;
  logic [bus_width-1:0] update_mask;
  logic [bus_width-1:0] stored;

  always_comb begin
    byte_mask = '0;
    for (int i = 0; i < strobe_width; i++) begin
      byte_mask[8*i+:8] = {8{strobe[i]}};
    end
  end

  // Only strobed bytes, and within them only the writable bits.
  assign update_mask = byte_mask & writable_mask;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      stored <= '0;
    end else if (write_hit) begin
      stored <= (stored & ~update_mask) | (write_data & update_mask);
    end
  end

  assign value = stored;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic [bus_width-1:0] read_value;

  // Hardware value shows through on every bit that is not writable.
  assign read_value = (stored & writable_mask) | (hw_value & ~writable_mask);

  always_comb begin
    reg_read_data = '0;
    if (reg_ready) begin
      reg_read_data = read_value;
    end
  end

  always_comb begin
    reg_status = reg_status_okay;
    if (write_hit && read_only) begin
      reg_status = reg_status_slave_error;
    end
  end

endmodule

/* test/reg_block_tb_table.svh */
// Columns: kind, address, write data, strobe, event pulses before the access,
// expected read data, expected status, expected data taken from hw_status.
task automatic load_table();
  // Reset state.
  add_row(kind_idle,  8'h00, 32'h0000_0000, 4'h0, 0, 32'h0000_0000, reg_status_okay, 1'b0);
  add_row(kind_read,  8'h08, 32'h0000_0000, 4'h0, 0, 32'h0000_0000, reg_status_okay, 1'b0);
  add_row(kind_read,  8'h00, 32'h0000_0000, 4'h0, 0, 32'h0000_0000, reg_status_okay, 1'b0);

  // Control register with partial strobes.
  add_row(kind_write, 8'h00, 32'h1122_3344, 4'hf, 0, 32'h0000_0000, reg_status_okay, 1'b0);
  add_row(kind_read,  8'h00, 32'h0000_0000, 4'h0, 0, 32'h1122_3344, reg_status_okay, 1'b0);
  add_row(kind_write, 8'h00, 32'haabb_ccdd, 4'h5, 0, 32'h0000_0000, reg_status_okay, 1'b0);
  add_row(kind_read,  8'h00, 32'h0000_0000, 4'h0, 0, 32'h11bb_33dd, reg_status_okay, 1'b0);
  add_row(kind_write, 8'h00, 32'h5566_7788, 4'ha, 0, 32'h0000_0000, reg_status_okay, 1'b0);
  add_row(kind_read,  8'h02, 32'h0000_0000, 4'h0, 0, 32'h55bb_77dd, reg_status_okay, 1'b0);
  add_row(kind_write, 8'h00, 32'hffff_ffff, 4'h0, 0, 32'h0000_0000, reg_status_okay, 1'b0);
  add_row(kind_read,  8'h00, 32'h0000_0000, 4'h0, 0, 32'h55bb_77dd, reg_status_okay, 1'b0);

  // Status register, read-only.
  add_row(kind_read,  8'h04, 32'h0000_0000, 4'h0, 0, 32'h0000_0000, reg_status_okay, 1'b1);
  add_row(kind_write, 8'h04, 32'hffff_ffff, 4'hf, 0, 32'h0000_0000,
          reg_status_slave_error, 1'b0);
  add_row(kind_read,  8'h04, 32'h0000_0000, 4'h0, 0, 32'h0000_0000, reg_status_okay, 1'b1);
  add_row(kind_read,  8'h00, 32'h0000_0000, 4'h0, 0, 32'h55bb_77dd, reg_status_okay, 1'b0);

  // Event counter, clear and saturation.
  add_row(kind_read,  8'h08, 32'h0000_0000, 4'h0, 5, 32'h0000_0005, reg_status_okay, 1'b0);
  add_row(kind_read,  8'h08, 32'h0000_0000, 4'h0, 0, 32'h0000_0005, reg_status_okay, 1'b0);
  add_row(kind_write, 8'h08, 32'h0000_1234, 4'h1, 0, 32'h0000_0000, reg_status_okay, 1'b0);
  add_row(kind_read,  8'h08, 32'h0000_0000, 4'h0, 0, 32'h0000_0000, reg_status_okay, 1'b0);
  add_row(kind_read,  8'h08, 32'h0000_0000, 4'h0, 65534, 32'h0000_fffe, reg_status_okay, 1'b0);
  add_row(kind_read,  8'h08, 32'h0000_0000, 4'h0, 3, 32'h0000_ffff, reg_status_okay, 1'b0);
  add_row(kind_write, 8'h08, 32'h0000_0000, 4'h0, 2, 32'h0000_0000, reg_status_okay, 1'b0);
  add_row(kind_read,  8'h08, 32'h0000_0000, 4'h0, 0, 32'h0000_0000, reg_status_okay, 1'b0);

  // Unmapped addresses.
  add_row(kind_read,  8'h0c, 32'h0000_0000, 4'h0, 0, 32'h0000_0000,
          reg_status_decode_error, 1'b0);
  add_row(kind_write, 8'h40, 32'hdead_beef, 4'hf, 0, 32'h0000_0000,
          reg_status_decode_error, 1'b0);
  add_row(kind_read,  8'hfc, 32'h0000_0000, 4'h0, 0, 32'h0000_0000,
          reg_status_decode_error, 1'b0);

  // Back-to-back accesses, valid stays high.
  add_row(kind_write, 8'h00, 32'h0102_0304, 4'hf, 0, 32'h0000_0000, reg_status_okay, 1'b0);
  add_row(kind_read,  8'h00, 32'h0000_0000, 4'h0, 0, 32'h0102_0304, reg_status_okay, 1'b0);
  add_row(kind_read,  8'h04, 32'h0000_0000, 4'h0, 0, 32'h0000_0000, reg_status_okay, 1'b1);
  add_row(kind_read,  8'h10, 32'h0000_0000, 4'h0, 0, 32'h0000_0000,
          reg_status_decode_error, 1'b0);
  add_row(kind_read,  8'h08, 32'h0000_0000, 4'h0, 0, 32'h0000_0000, reg_status_okay, 1'b0);
  add_row(kind_write, 8'h00, 32'hcafe_f00d, 4'h3, 0, 32'h0000_0000, reg_status_okay, 1'b0);
  add_row(kind_read,  8'h00, 32'h0000_0000, 4'h0, 0, 32'h0102_f00d, reg_status_okay, 1'b0);
  add_row(kind_idle,  8'h00, 32'h0000_0000, 4'h0, 0, 32'h0000_0000, reg_status_okay, 1'b0);
endtask

/* test/reg_block_tb.sv */
`timescale 1ns/1ps

module reg_block_tb;
  import reg_block_pkg::*;

  localparam int bus_width     = 32;
  localparam int address_width = 8;
  localparam int max_rows      = 64;

  localparam logic [1:0] kind_idle  = 2'd0;
  localparam logic [1:0] kind_read  = 2'd1;
  localparam logic [1:0] kind_write = 2'd2;

  logic                        i_clk;
  logic                        i_rst_n;
  logic                        valid;
  logic [address_width-1:0]    address;
  logic                        write;
  logic [bus_width-1:0]        write_data;
  logic [bus_width/8-1:0]      strobe;
  logic                        ready;
  logic [reg_status_width-1:0] status;
  logic [bus_width-1:0]        read_data;
  logic [bus_width-1:0]        hw_status;
  logic                        event_pulse;
  logic [bus_width-1:0]        ctrl_value;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus table.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic [1:0]                  row_kind       [0:max_rows-1];
  logic [address_width-1:0]    row_address    [0:max_rows-1];
  logic [bus_width-1:0]        row_write_data [0:max_rows-1];
  logic [bus_width/8-1:0]      row_strobe     [0:max_rows-1];
  int                          row_pulses     [0:max_rows-1];
  logic [bus_width-1:0]        row_data       [0:max_rows-1];
  logic [reg_status_width-1:0] row_status     [0:max_rows-1];
  bit                          row_hw         [0:max_rows-1];
  int                          row_count;

  int                          cycle_count;
  int                          cycle_limit;
  int                          max_pulses;
  int unsigned                 seed;
  logic [bus_width-1:0]        ctrl_model;

  reg_block #(
    .bus_width     (bus_width),
    .address_width (address_width)
  ) i_reg_block (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .valid       (valid),
    .address     (address),
    .write       (write),
    .write_data  (write_data),
    .strobe      (strobe),
    .ready       (ready),
    .status      (status),
    .read_data   (read_data),
    .hw_status   (hw_status),
    .event_pulse (event_pulse),
    .ctrl_value  (ctrl_value)
  );

  always #2 i_clk = ~i_clk;

  task automatic add_row(
    input logic [1:0]                  kind,
    input logic [address_width-1:0]    addr,
    input logic [bus_width-1:0]        data,
    input logic [bus_width/8-1:0]      strb,
    input int                          pulses,
    input logic [bus_width-1:0]        exp_data,
    input logic [reg_status_width-1:0] exp_status,
    input bit                          exp_hw
  );
    row_kind[row_count]       = kind;
    row_address[row_count]    = addr;
    row_write_data[row_count] = data;
    row_strobe[row_count]     = strb;
    row_pulses[row_count]     = pulses;
    row_data[row_count]       = exp_data;
    row_status[row_count]     = exp_status;
    row_hw[row_count]         = exp_hw;
    row_count++;
  endtask

  `include "reg_block_tb_table.svh"

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH time=%0t signal=%s actual=0x%0h expected=0x%0h",
               $time, name, actual, expected);
      $display("SOME TESTS FAILED");
      $fatal(1, "Stopped at the first wrong value.");
    end
  endtask

  // Byte lanes with a strobe bit take the new data.
  function automatic logic [bus_width-1:0] merge_bytes(input logic [bus_width-1:0] old_value,
                                                       input logic [bus_width-1:0] data,
                                                       input logic [bus_width/8-1:0] strb);
    logic [bus_width-1:0] result;
    result = old_value;
    for (int b = 0; b < bus_width / 8; b++) begin
      if (strb[b]) begin
        result[8*b+:8] = data[8*b+:8];
      end
    end
    return result;
  endfunction

  task automatic wait_for_ready(input int row, output int waited);
    waited = 0;
    while (!ready && waited < 1) begin
      @(negedge i_clk);
      #1;
      waited++;
    end
    if (!ready) begin
      $display("Row %0d: ready did not arrive within one cycle of valid.", row);
      $display("SOME TESTS FAILED");
      $fatal(1, "Handshake timed out.");
    end
  endtask

  task automatic apply_row(input int row);
    logic [bus_width-1:0] expected_data;
    int                   waited;
    for (int p = 0; p < row_pulses[row]; p++) begin
      @(negedge i_clk);
      valid       = 1'b0;
      event_pulse = 1'b1;
    end
    @(negedge i_clk);
    event_pulse = 1'b0;
    hw_status   = $urandom();
    valid       = (row_kind[row] != kind_idle);
    address     = row_address[row];
    write       = (row_kind[row] == kind_write);
    write_data  = row_write_data[row];
    strobe      = row_strobe[row];
    #1;
    check_value($sformatf("row %0d ctrl_value", row), ctrl_value, ctrl_model);
    if (row_kind[row] == kind_idle) begin
      check_value($sformatf("row %0d ready", row), ready, 1'b0);
    end else begin
      wait_for_ready(row, waited);
      check_value($sformatf("row %0d wait states", row), waited, 0);
      check_value($sformatf("row %0d status", row), status, row_status[row]);
      if (row_kind[row] == kind_read) begin
        expected_data = row_hw[row] ? hw_status : row_data[row];
        check_value($sformatf("row %0d read_data", row), read_data, expected_data);
      end else if (row_address[row][address_width-1:2] == '0) begin
        ctrl_model = merge_bytes(ctrl_model, row_write_data[row], row_strobe[row]);
      end
    end
  endtask

  // Watchdog on the total cycle count.
  always @(posedge i_clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Run did not finish within %0d cycles.", cycle_limit);
      $display("SOME TESTS FAILED");
      $fatal(1, "Watchdog expired.");
    end
  end

  initial begin
    i_clk       = 1'b0;
    i_rst_n     = 1'b0;
    valid       = 1'b0;
    address     = '0;
    write       = 1'b0;
    write_data  = '0;
    strobe      = '0;
    event_pulse = 1'b0;
    seed        = 32'h4724;
    hw_status   = $urandom(seed);
    cycle_count = 0;
    cycle_limit = 0;
    row_count   = 0;
    ctrl_model  = '0;
    load_table();
    max_pulses = 0;
    for (int r = 0; r < row_count; r++) begin
      if (row_pulses[r] > max_pulses) begin
        max_pulses = row_pulses[r];
      end
    end
    cycle_limit = 5 + row_count * (max_pulses + 3) + 100;
    repeat (5) @(negedge i_clk);
    i_rst_n = 1'b1;
    for (int r = 0; r < row_count; r++) begin
      apply_row(r);
    end
    @(negedge i_clk);
    valid = 1'b0;
    @(negedge i_clk);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
